// ==== verilog/grt_pkg.sv ====
package grt_pkg;

   ////////////////////
   // Widths
   ////////////////////

   // Upper CU id bits pick the table, lower bits the CU inside it
   localparam int TBL_ADDR_W = 2;
   localparam int NUM_TABLES = 1 << TBL_ADDR_W;
   localparam int LCU_W      = 2;
   localparam int NUM_LCU    = 1 << LCU_W;
   localparam int CU_ID_W    = TBL_ADDR_W + LCU_W;

   localparam int WG_ID_W    = 4;
   localparam int NUM_WG     = 1 << WG_ID_W;

   // One extra bit on top so a full CU worth of VGPRs fits
   localparam int VGPR_W     = 10;

   ////////////////////
   // Types
   ////////////////////

   typedef logic [CU_ID_W-1:0]    cu_id_t;
   typedef logic [TBL_ADDR_W-1:0] tbl_addr_t;
   typedef logic [LCU_W-1:0]      lcu_id_t;
   typedef logic [WG_ID_W-1:0]    wg_id_t;
   typedef logic [VGPR_W:0]       vgpr_amt_t;
   typedef logic [NUM_TABLES-1:0] tbl_mask_t;

   typedef enum logic [1:0] {
      OP_NONE    = 2'd0,
      OP_ALLOC   = 2'd1,
      OP_DEALLOC = 2'd2
   } grt_op_e;

endpackage

// ==== verilog/grt_request_decoder.sv ====
module grt_request_decoder
   import grt_pkg::*;
(
   input  logic      clk,
   input  logic      rst,

   // Controller and GPU side strobes
   input  logic      alloc_valid_i,
   input  wg_id_t    alloc_wg_id_i,
   input  cu_id_t    alloc_cu_id_i,
   input  vgpr_amt_t alloc_vgpr_size_i,
   input  logic      dealloc_valid_i,
   input  wg_id_t    dealloc_wg_id_i,
   input  cu_id_t    dealloc_cu_id_i,

   // Table bank inputs
   output tbl_mask_t tbl_sel_o,
   output grt_op_e   op_o,
   output lcu_id_t   lcu_id_o,
   output wg_id_t    wg_id_o,
   output vgpr_amt_t vgpr_size_o,

   // In-flight table write
   output logic      inflight_wr_o,
   output tbl_addr_t inflight_addr_o,
   output lcu_id_t   inflight_lcu_o,
   output wg_id_t    inflight_wg_o,
   output grt_op_e   inflight_op_o
);

   logic      alloc_q, dealloc_q;
   wg_id_t    alloc_wg_q, dealloc_wg_q;
   cu_id_t    alloc_cu_q, dealloc_cu_q;
   vgpr_amt_t alloc_size_q;

   grt_op_e   dec_op_d;
   cu_id_t    dec_cu_d;
   wg_id_t    dec_wg_d;

   grt_op_e   dec_op_q;
   tbl_mask_t dec_sel_q;
   tbl_addr_t dec_addr_q;
   lcu_id_t   dec_lcu_q;
   wg_id_t    dec_wg_q;
   vgpr_amt_t dec_size_q;

   tbl_mask_t in_sel_q;
   grt_op_e   in_op_q;
   lcu_id_t   in_lcu_q;
   wg_id_t    in_wg_q;
   vgpr_amt_t in_size_q;

   ////////////////////
   // Input flops
   ////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         alloc_q   <= 1'b0;
         dealloc_q <= 1'b0;
      end else begin
         alloc_q   <= alloc_valid_i;
         dealloc_q <= dealloc_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      alloc_wg_q   <= alloc_wg_id_i;
      alloc_cu_q   <= alloc_cu_id_i;
      alloc_size_q <= alloc_vgpr_size_i;
      dealloc_wg_q <= dealloc_wg_id_i;
      dealloc_cu_q <= dealloc_cu_id_i;
   end

   ////////////////////
   // Decode
   ////////////////////

   // Alloc wins, a dealloc in the same cycle is dropped
   always_comb begin
      dec_op_d = OP_NONE;
      dec_cu_d = dealloc_cu_q;
      dec_wg_d = dealloc_wg_q;
      if (alloc_q) begin
         dec_op_d = OP_ALLOC;
         dec_cu_d = alloc_cu_q;
         dec_wg_d = alloc_wg_q;
      end else if (dealloc_q) begin
         dec_op_d = OP_DEALLOC;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dec_op_q  <= OP_NONE;
         dec_sel_q <= '0;
         in_op_q   <= OP_NONE;
         in_sel_q  <= '0;
      end else begin
         dec_op_q  <= dec_op_d;
         dec_sel_q <= (dec_op_d != OP_NONE) ?
                      tbl_mask_t'(1) << dec_cu_d[CU_ID_W-1 -: TBL_ADDR_W] : '0;
         // Table input stage
         in_op_q   <= dec_op_q;
         in_sel_q  <= dec_sel_q;
      end
   end

   always_ff @(posedge clk) begin
      dec_addr_q <= dec_cu_d[CU_ID_W-1 -: TBL_ADDR_W];
      dec_lcu_q  <= dec_cu_d[LCU_W-1:0];
      dec_wg_q   <= dec_wg_d;
      dec_size_q <= alloc_size_q;
      in_lcu_q   <= dec_lcu_q;
      in_wg_q    <= dec_wg_q;
      in_size_q  <= dec_size_q;
   end

   assign tbl_sel_o   = in_sel_q;
   assign op_o        = in_op_q;
   assign lcu_id_o    = in_lcu_q;
   assign wg_id_o     = in_wg_q;
   assign vgpr_size_o = in_size_q;

   // Entry lands in the in-flight table on the edge the bank gets its op
   assign inflight_wr_o   = (dec_op_q != OP_NONE);
   assign inflight_addr_o = dec_addr_q;
   assign inflight_lcu_o  = dec_lcu_q;
   assign inflight_wg_o   = dec_wg_q;
   assign inflight_op_o   = dec_op_q;

endmodule

// ==== verilog/vgpr_table_bank.sv ====
module vgpr_table_bank
   import grt_pkg::*;
#(
   parameter int VGPR_CAPACITY = 1024
) (
   input  logic                         clk,
   input  logic                         rst,

   input  tbl_mask_t                    tbl_sel_i,
   input  grt_op_e                      op_i,
   input  lcu_id_t                      lcu_id_i,
   input  wg_id_t                       wg_id_i,
   input  vgpr_amt_t                    vgpr_size_i,
   input  tbl_mask_t                    serviced_i,

   output tbl_mask_t                    pending_o,
   output vgpr_amt_t [NUM_TABLES-1:0]   free_cnt_o
);

   localparam vgpr_amt_t CAPACITY = vgpr_amt_t'(VGPR_CAPACITY);

   for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table

      // Amount held by each workgroup, and the sum per CU
      vgpr_amt_t wg_amt [NUM_LCU][NUM_WG];
      vgpr_amt_t cu_total [NUM_LCU];

      vgpr_amt_t new_total;
      vgpr_amt_t free_q;
      logic      pend_q;
      logic      upd;

      assign upd = tbl_sel_i[t] && (op_i != OP_NONE);

      always_comb begin
         if (op_i == OP_ALLOC) begin
            new_total = cu_total[lcu_id_i] + vgpr_size_i;
         end else begin
            new_total = cu_total[lcu_id_i] - wg_amt[lcu_id_i][wg_id_i];
         end
      end

      ////////////////////
      // Storage update
      ////////////////////

      always_ff @(posedge clk or posedge rst) begin
         if (rst) begin
            for (int c = 0; c < NUM_LCU; c++) begin
               cu_total[c] <= '0;
               for (int w = 0; w < NUM_WG; w++) begin
                  wg_amt[c][w] <= '0;
               end
            end
            free_q <= CAPACITY;
            pend_q <= 1'b0;
         end else begin
            if (upd) begin
               cu_total[lcu_id_i] <= new_total;
               if (op_i == OP_ALLOC) begin
                  wg_amt[lcu_id_i][wg_id_i] <= vgpr_size_i;
               end else begin
                  wg_amt[lcu_id_i][wg_id_i] <= '0;
               end
               // Result waits here until the arbiter takes it
               free_q <= CAPACITY - new_total;
               pend_q <= 1'b1;
            end else if (serviced_i[t]) begin
               pend_q <= 1'b0;
            end
         end
      end

      assign pending_o[t]  = pend_q;
      assign free_cnt_o[t] = free_q;

      ////////////////////
      // Source rules
      ////////////////////

      // No new op before the previous result of this table drained
      a_no_op_while_pending : assert property (
         @(posedge clk) disable iff (rst)
         upd |-> !pend_q
      ) else $error("op sent to table %0d while its result is pending", t);

      // Dispatcher only places a workgroup where it fits
      a_alloc_fits : assert property (
         @(posedge clk) disable iff (rst)
         (upd && op_i == OP_ALLOC) |-> (vgpr_size_i <= CAPACITY - cu_total[lcu_id_i])
      ) else $error("alloc of %0d exceeds free count on table %0d", vgpr_size_i, t);

   end

endmodule

// ==== verilog/grt_completion_arbiter.sv ====
module grt_completion_arbiter
   import grt_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,

   // From the table bank
   input  tbl_mask_t                  pending_i,
   input  vgpr_amt_t [NUM_TABLES-1:0] free_cnt_i,

   // In-flight table write from the decoder
   input  logic                       inflight_wr_i,
   input  tbl_addr_t                  inflight_addr_i,
   input  lcu_id_t                    inflight_lcu_i,
   input  wg_id_t                     inflight_wg_i,
   input  grt_op_e                    inflight_op_i,

   output tbl_mask_t                  serviced_o,
   output logic                       alloc_done_o,
   output logic                       dealloc_done_o,
   output wg_id_t                     done_wg_id_o,
   output cu_id_t                     done_cu_id_o,
   output logic                       cam_up_valid_o,
   output cu_id_t                     cam_up_cu_id_o,
   output vgpr_amt_t                  cam_up_vgpr_free_o
);

   // One entry per resource table
   lcu_id_t   ifl_lcu [NUM_TABLES];
   wg_id_t    ifl_wg  [NUM_TABLES];
   grt_op_e   ifl_op  [NUM_TABLES];

   tbl_mask_t cand;
   tbl_mask_t pick_mask;
   tbl_addr_t pick_idx;
   logic      pick_valid;

   tbl_mask_t serviced_q;
   tbl_addr_t sel_idx_q;
   logic      sel_valid_q;

   grt_op_e   ent_op;
   lcu_id_t   ent_lcu;
   wg_id_t    ent_wg;

   logic      alloc_done_q, dealloc_done_q;
   wg_id_t    done_wg_q;
   cu_id_t    done_cu_q;
   vgpr_amt_t free_q;

   ////////////////////
   // In-flight table
   ////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_TABLES; i++) begin
            ifl_op[i] <= OP_NONE;
         end
      end else if (inflight_wr_i) begin
         ifl_op[inflight_addr_i] <= inflight_op_i;
      end
   end

   always_ff @(posedge clk) begin
      if (inflight_wr_i) begin
         ifl_lcu[inflight_addr_i] <= inflight_lcu_i;
         ifl_wg[inflight_addr_i]  <= inflight_wg_i;
      end
   end

   ////////////////////
   // Priority encoder
   ////////////////////

   // Lowest pending table except the one taken last cycle
   always_comb begin
      cand       = pending_i & ~serviced_q;
      pick_idx   = '0;
      pick_valid = 1'b0;
      for (int i = NUM_TABLES - 1; i >= 0; i--) begin
         if (cand[i]) begin
            pick_idx   = tbl_addr_t'(i);
            pick_valid = 1'b1;
         end
      end
      pick_mask = '0;
      if (pick_valid) begin
         pick_mask[pick_idx] = 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         serviced_q  <= '0;
         sel_idx_q   <= '0;
         sel_valid_q <= 1'b0;
      end else begin
         serviced_q  <= pick_mask;
         sel_idx_q   <= pick_idx;
         sel_valid_q <= pick_valid;
      end
   end

   ////////////////////
   // Done and CAM update
   ////////////////////

   assign ent_op  = ifl_op[sel_idx_q];
   assign ent_lcu = ifl_lcu[sel_idx_q];
   assign ent_wg  = ifl_wg[sel_idx_q];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         alloc_done_q   <= 1'b0;
         dealloc_done_q <= 1'b0;
      end else begin
         alloc_done_q   <= sel_valid_q && (ent_op == OP_ALLOC);
         dealloc_done_q <= sel_valid_q && (ent_op == OP_DEALLOC);
      end
   end

   // Full CU id rebuilt from table index and local CU
   always_ff @(posedge clk) begin
      done_wg_q <= ent_wg;
      done_cu_q <= {sel_idx_q, ent_lcu};
      free_q    <= free_cnt_i[sel_idx_q];
   end

   assign serviced_o         = serviced_q;
   assign alloc_done_o       = alloc_done_q;
   assign dealloc_done_o     = dealloc_done_q;
   assign done_wg_id_o       = done_wg_q;
   assign done_cu_id_o       = done_cu_q;
   assign cam_up_valid_o     = alloc_done_q | dealloc_done_q;
   assign cam_up_cu_id_o     = done_cu_q;
   assign cam_up_vgpr_free_o = free_q;

   // One table at a time and only one whose result still waits in the bank
   a_serviced_onehot_pending : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(serviced_o) && ((serviced_o & ~pending_i) == '0)
   ) else $error("serviced mask %b not a single pending table %b", serviced_o, pending_i);

endmodule

// ==== verilog/global_resource_table.sv ====
module global_resource_table
   import grt_pkg::*;
#(
   parameter int VGPR_CAPACITY = 1024
) (
   input  logic      clk,
   input  logic      rst,

   // Alloc request from the controller
   input  logic      alloc_valid_i,
   input  wg_id_t    alloc_wg_id_i,
   input  cu_id_t    alloc_cu_id_i,
   input  vgpr_amt_t alloc_vgpr_size_i,

   // Dealloc request from the GPU side
   input  logic      dealloc_valid_i,
   input  wg_id_t    dealloc_wg_id_i,
   input  cu_id_t    dealloc_cu_id_i,

   output logic      alloc_done_o,
   output logic      dealloc_done_o,
   output wg_id_t    done_wg_id_o,
   output cu_id_t    done_cu_id_o,

   output logic      cam_up_valid_o,
   output cu_id_t    cam_up_cu_id_o,
   output vgpr_amt_t cam_up_vgpr_free_o
);

   tbl_mask_t                  tbl_sel;
   grt_op_e                    tbl_op;
   lcu_id_t                    tbl_lcu;
   wg_id_t                     tbl_wg;
   vgpr_amt_t                  tbl_size;

   logic                       ifl_wr;
   tbl_addr_t                  ifl_addr;
   lcu_id_t                    ifl_lcu;
   wg_id_t                     ifl_wg;
   grt_op_e                    ifl_op;

   tbl_mask_t                  pending;
   tbl_mask_t                  serviced;
   vgpr_amt_t [NUM_TABLES-1:0] free_cnt;

   grt_request_decoder decoder_i (
      .clk               (clk),
      .rst               (rst),
      .alloc_valid_i     (alloc_valid_i),
      .alloc_wg_id_i     (alloc_wg_id_i),
      .alloc_cu_id_i     (alloc_cu_id_i),
      .alloc_vgpr_size_i (alloc_vgpr_size_i),
      .dealloc_valid_i   (dealloc_valid_i),
      .dealloc_wg_id_i   (dealloc_wg_id_i),
      .dealloc_cu_id_i   (dealloc_cu_id_i),
      .tbl_sel_o         (tbl_sel),
      .op_o              (tbl_op),
      .lcu_id_o          (tbl_lcu),
      .wg_id_o           (tbl_wg),
      .vgpr_size_o       (tbl_size),
      .inflight_wr_o     (ifl_wr),
      .inflight_addr_o   (ifl_addr),
      .inflight_lcu_o    (ifl_lcu),
      .inflight_wg_o     (ifl_wg),
      .inflight_op_o     (ifl_op)
   );

   vgpr_table_bank #(
      .VGPR_CAPACITY (VGPR_CAPACITY)
   ) bank_i (
      .clk         (clk),
      .rst         (rst),
      .tbl_sel_i   (tbl_sel),
      .op_i        (tbl_op),
      .lcu_id_i    (tbl_lcu),
      .wg_id_i     (tbl_wg),
      .vgpr_size_i (tbl_size),
      .serviced_i  (serviced),
      .pending_o   (pending),
      .free_cnt_o  (free_cnt)
   );

   grt_completion_arbiter arbiter_i (
      .clk                (clk),
      .rst                (rst),
      .pending_i          (pending),
      .free_cnt_i         (free_cnt),
      .inflight_wr_i      (ifl_wr),
      .inflight_addr_i    (ifl_addr),
      .inflight_lcu_i     (ifl_lcu),
      .inflight_wg_i      (ifl_wg),
      .inflight_op_i      (ifl_op),
      .serviced_o         (serviced),
      .alloc_done_o       (alloc_done_o),
      .dealloc_done_o     (dealloc_done_o),
      .done_wg_id_o       (done_wg_id_o),
      .done_cu_id_o       (done_cu_id_o),
      .cam_up_valid_o     (cam_up_valid_o),
      .cam_up_cu_id_o     (cam_up_cu_id_o),
      .cam_up_vgpr_free_o (cam_up_vgpr_free_o)
   );

endmodule

// ==== include/grt_tb_stimulus.svh ====
`ifndef GRT_TB_STIMULUS_SVH
`define GRT_TB_STIMULUS_SVH

// Both kind allocs wg_id on cu_id and deallocs wg_id - 1 on the same CU
typedef enum logic [1:0] {
   STIM_ALLOC,
   STIM_DEALLOC,
   STIM_BOTH
} stim_kind_e;

// Size zero draws an LFSR size
// A set b2b flag issues the next row on the next cycle
typedef struct packed {
   stim_kind_e kind;
   cu_id_t     cu_id;
   wg_id_t     wg_id;
   vgpr_amt_t  size;
   logic       b2b;
} stim_row_t;

localparam int NUM_STIM_ROWS = 12;

localparam stim_row_t STIM_ROWS [NUM_STIM_ROWS] = '{
   '{STIM_ALLOC,   4'h5, 4'd1,  11'd100, 1'b0},
   '{STIM_ALLOC,   4'h5, 4'd2,  11'd0,   1'b0},
   '{STIM_DEALLOC, 4'h5, 4'd1,  11'd0,   1'b0},
   // One alloc per table, back to back
   '{STIM_ALLOC,   4'h2, 4'd8,  11'd64,  1'b1},
   '{STIM_ALLOC,   4'h7, 4'd9,  11'd0,   1'b1},
   '{STIM_ALLOC,   4'h9, 4'd10, 11'd256, 1'b1},
   '{STIM_ALLOC,   4'he, 4'd11, 11'd0,   1'b0},
   // Dealloc half of this row is lost so wg 2 stays held
   '{STIM_BOTH,    4'h5, 4'd3,  11'd32,  1'b0},
   '{STIM_DEALLOC, 4'h5, 4'd2,  11'd0,   1'b0},
   '{STIM_DEALLOC, 4'h5, 4'd3,  11'd0,   1'b0},
   '{STIM_DEALLOC, 4'h2, 4'd8,  11'd0,   1'b1},
   '{STIM_DEALLOC, 4'h7, 4'd9,  11'd0,   1'b0}
};

`endif

// ==== test/tb_global_resource_table.sv ====
module tb_global_resource_table
   import grt_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CAPACITY   = 1024;
   localparam int TIMEOUT    = 200;
   localparam int NUM_RANDOM = 48;

   `include "grt_tb_stimulus.svh"

   // One expected completion matched by the table its CU id selects
   typedef struct packed {
      grt_op_e   op;
      cu_id_t    cu;
      wg_id_t    wg;
      vgpr_amt_t free;
   } result_t;

   logic        clk;
   logic        rst;
   logic        alloc_valid;
   wg_id_t      alloc_wg;
   cu_id_t      alloc_cu;
   vgpr_amt_t   alloc_size;
   logic        dealloc_valid;
   wg_id_t      dealloc_wg;
   cu_id_t      dealloc_cu;
   logic        alloc_done;
   logic        dealloc_done;
   wg_id_t      done_wg;
   cu_id_t      done_cu;
   logic        cam_valid;
   cu_id_t      cam_cu;
   vgpr_amt_t   cam_free;

   result_t     expect_q [$];
   int          model_amt [1 << CU_ID_W][NUM_WG];
   int          model_total [1 << CU_ID_W];
   logic [31:0] lfsr_state;
   int          checks;
   int          errors;
   int          tests;
   int          tests_failed;
   logic        timed_out;

   global_resource_table #(
      .VGPR_CAPACITY (CAPACITY)
   ) dut_i (
      .clk                (clk),
      .rst                (rst),
      .alloc_valid_i      (alloc_valid),
      .alloc_wg_id_i      (alloc_wg),
      .alloc_cu_id_i      (alloc_cu),
      .alloc_vgpr_size_i  (alloc_size),
      .dealloc_valid_i    (dealloc_valid),
      .dealloc_wg_id_i    (dealloc_wg),
      .dealloc_cu_id_i    (dealloc_cu),
      .alloc_done_o       (alloc_done),
      .dealloc_done_o     (dealloc_done),
      .done_wg_id_o       (done_wg),
      .done_cu_id_o       (done_cu),
      .cam_up_valid_o     (cam_valid),
      .cam_up_cu_id_o     (cam_cu),
      .cam_up_vgpr_free_o (cam_free)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_bits(int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic tbl_addr_t table_of(cu_id_t cu);
      return cu[CU_ID_W-1 -: TBL_ADDR_W];
   endfunction

   function automatic logic table_busy(tbl_addr_t t);
      logic busy;
      busy = 1'b0;
      foreach (expect_q[i]) begin
         if (table_of(expect_q[i].cu) == t) busy = 1'b1;
      end
      return busy;
   endfunction

   // Never more than the CU still has free
   function automatic vgpr_amt_t draw_size(cu_id_t cu);
      int room;
      room = CAPACITY - model_total[cu];
      if (room <= 0) return '0;
      return vgpr_amt_t'(1 + lfsr_bits(8) % room);
   endfunction

   task automatic check_value(string name, int got, int expv);
      checks++;
      if (got != expv) begin
         $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, expv);
         errors++;
      end
   endtask

   task automatic clear_inputs();
      alloc_valid   = 1'b0;
      alloc_wg      = '0;
      alloc_cu      = '0;
      alloc_size    = '0;
      dealloc_valid = 1'b0;
      dealloc_wg    = '0;
      dealloc_cu    = '0;
   endtask

   // Drives one request and updates the reference model
   task automatic issue(stim_kind_e kind, cu_id_t cu, wg_id_t wg, vgpr_amt_t size);
      result_t r;
      r.cu = cu;
      r.wg = wg;
      if (kind == STIM_DEALLOC) begin
         dealloc_valid = 1'b1;
         dealloc_cu    = cu;
         dealloc_wg    = wg;
         model_total[cu] -= model_amt[cu][wg];
         model_amt[cu][wg] = 0;
         r.op = OP_DEALLOC;
      end else begin
         if (size == 0) size = draw_size(cu);
         alloc_valid = 1'b1;
         alloc_cu    = cu;
         alloc_wg    = wg;
         alloc_size  = size;
         model_total[cu] += int'(size);
         model_amt[cu][wg] = int'(size);
         r.op = OP_ALLOC;
         // Model ignores the same-cycle dealloc since the DUT drops it
         if (kind == STIM_BOTH) begin
            dealloc_valid = 1'b1;
            dealloc_cu    = cu;
            dealloc_wg    = wg - 4'd1;
         end
      end
      r.free = vgpr_amt_t'(CAPACITY - model_total[cu]);
      expect_q.push_back(r);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (expect_q.size() != 0 && n < TIMEOUT);
      if (expect_q.size() != 0) begin
         $display("ERROR: %0d results still outstanding after %0d cycles",
                  expect_q.size(), TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_table_free(tbl_addr_t t);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (table_busy(t) && n < TIMEOUT);
      if (table_busy(t)) begin
         $display("ERROR: table %0d gave no done pulse within %0d cycles", t, TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   task automatic report_test(string name, int err0);
      tests++;
      if (errors == err0) begin
         $display("test %-24s ok", name);
      end else begin
         tests_failed++;
         $display("test %-24s %0d errors", name, errors - err0);
      end
   endtask

   ////////////////////
   // Done monitor
   ////////////////////

   task automatic match_done();
      int      idx;
      result_t r;
      idx = -1;
      for (int i = expect_q.size() - 1; i >= 0; i--) begin
         if (table_of(expect_q[i].cu) == table_of(done_cu)) idx = i;
      end
      if (idx < 0) begin
         $display("ERROR at %0t ns: done pulse for table %0d with no request outstanding",
                  $time, table_of(done_cu));
         errors++;
      end else begin
         r = expect_q[idx];
         expect_q.delete(idx);
         check_value("cam_up_valid_o", cam_valid, 1);
         check_value("alloc_done_o", alloc_done, r.op == OP_ALLOC);
         check_value("dealloc_done_o", dealloc_done, r.op == OP_DEALLOC);
         check_value("done_cu_id_o", done_cu, r.cu);
         check_value("done_wg_id_o", done_wg, r.wg);
         check_value("cam_up_cu_id_o", cam_cu, r.cu);
         check_value("cam_up_vgpr_free_o", cam_free, r.free);
      end
   endtask

   always @(negedge clk) begin
      if (!rst && (alloc_done || dealloc_done || cam_valid)) begin
         match_done();
      end
   end

   ////////////////////
   // Tests
   ////////////////////

   task automatic check_idle(int cycles);
      int err0;
      err0 = errors;
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         check_value("alloc_done_o", alloc_done, 0);
         check_value("dealloc_done_o", dealloc_done, 0);
         check_value("cam_up_valid_o", cam_valid, 0);
      end
      report_test("idle after reset", err0);
   endtask

   task automatic run_rows(string name, int first, int last);
      int err0;
      err0 = errors;
      for (int i = first; i <= last; i++) begin
         if (!timed_out) begin
            issue(STIM_ROWS[i].kind, STIM_ROWS[i].cu_id, STIM_ROWS[i].wg_id, STIM_ROWS[i].size);
            @(negedge clk);
            clear_inputs();
            if (!STIM_ROWS[i].b2b) begin
               wait_drain();
               @(negedge clk);
            end
         end
      end
      report_test(name, err0);
   endtask

   // Held workgroups get freed and empty slots get a new alloc
   task automatic run_random(int count);
      cu_id_t cu;
      wg_id_t wg;
      int     err0;
      err0 = errors;
      for (int i = 0; i < count; i++) begin
         if (!timed_out) begin
            cu = cu_id_t'(lfsr_bits(CU_ID_W));
            wg = wg_id_t'(lfsr_bits(WG_ID_W));
            wait_table_free(table_of(cu));
            if (!timed_out) begin
               @(negedge clk);
               if (model_amt[cu][wg] != 0) begin
                  issue(STIM_DEALLOC, cu, wg, '0);
               end else begin
                  issue(STIM_ALLOC, cu, wg, '0);
               end
               @(negedge clk);
               clear_inputs();
            end
         end
      end
      if (!timed_out) wait_drain();
      report_test("random stream", err0);
   endtask

   initial begin
      rst          = 1'b1;
      lfsr_state   = 32'h7c48_f3d0;
      checks       = 0;
      errors       = 0;
      tests        = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      clear_inputs();
      for (int c = 0; c < (1 << CU_ID_W); c++) begin
         model_total[c] = 0;
         for (int w = 0; w < NUM_WG; w++) begin
            model_amt[c][w] = 0;
         end
      end

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      check_idle(8);
      if (!timed_out) run_rows("single allocs", 0, 1);
      if (!timed_out) run_rows("dealloc", 2, 2);
      if (!timed_out) run_rows("back-to-back tables", 3, 6);
      if (!timed_out) run_rows("alloc wins over dealloc", 7, 9);
      if (!timed_out) run_rows("dealloc drain", 10, 11);
      if (!timed_out) run_random(NUM_RANDOM);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, tests_failed, checks, errors);
      if (timed_out || errors != 0) begin
         $display("TEST FAILED");
      end else begin
         $display("TEST PASSED");
      end
      $finish;
   end

endmodule

// ==== global_resource_table.f ====
+incdir+include
verilog/grt_pkg.sv
verilog/grt_request_decoder.sv
verilog/vgpr_table_bank.sv
verilog/grt_completion_arbiter.sv
verilog/global_resource_table.sv
test/tb_global_resource_table.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the global resource table testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f global_resource_table.f \
   --top-module tb_global_resource_table \
   -o sim_global_resource_table

./obj_dir/sim_global_resource_table | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
exit 0
